// File: tb.f
+incdir+bench
rtl/exec_pkg.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/csr_access.sv
rtl/trap_control.sv
rtl/execute_stage.sv
bench/tb_execute.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_execute -o tb_execute
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_execute
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: bench/execute_model.svh
// reference model for the execute stage testbench
// expected results, branch decisions, csr requests and traps
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

//////////////////////////////////////////////////
// alu and branch reference
//////////////////////////////////////////////////

function automatic logic [xlen-1:0] alu_reference(op_e op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b, logic [xlen-1:0] pc,
                                                  logic [xlen-1:0] csr_rdata);
    logic [4:0] shamt;
    shamt = b[4:0];
    case (op)
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: return csr_rdata;
        SUB:       return a - b;
        JAL, JALR: return pc + 32'd4;
        SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:      return (a < b) ? 32'd1 : 32'd0;
        XOR:       return a ^ b;
        OR:        return a | b;
        AND:       return a & b;
        SLL:       return a << shamt;
        SRL:       return a >> shamt;
        SRA:       return $unsigned($signed(a) >>> shamt);
        LUI:       return b;
        default:   return a + b;
    endcase
endfunction

function automatic logic branch_taken(op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
        BEQ:       return a == b;
        BNE:       return a != b;
        BLT:       return $signed(a) < $signed(b);
        BGE:       return $signed(a) >= $signed(b);
        BLTU:      return a < b;
        BGEU:      return a >= b;
        JAL, JALR: return 1'b1;
        default:   return 1'b0;
    endcase
endfunction

function automatic logic [xlen-1:0] branch_target(op_e op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b, logic [xlen-1:0] c,
                                                  logic [xlen-1:0] pc);
    if (op == JALR)
        return (a + b) & 32'hffff_fffe;
    if (op == JAL)
        return a + b;
    return pc + c;
endfunction

// stores and conditional branches have no destination register
function automatic logic writes_register(op_e op);
    return !(op inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU});
endfunction

//////////////////////////////////////////////////
// csr reference
//////////////////////////////////////////////////

// returns {read, write} before the permission check
function automatic logic [1:0] csr_enables(op_e op, logic [xlen-1:0] instr);
    logic rd_nonzero;
    logic rs1_nonzero;
    rd_nonzero  = (instr[11:7] != 5'd0);
    rs1_nonzero = (instr[19:15] != 5'd0);
    if (op == CSRRW || op == CSRRWI)
        return {rd_nonzero, 1'b1};
    if (op inside {CSRRS, CSRRC, CSRRSI, CSRRCI})
        return {1'b1, rs1_nonzero};
    return 2'b00;
endfunction

function automatic logic csr_violation(op_e op, logic [xlen-1:0] instr, priv_e priv);
    logic [1:0] en;
    logic [1:0] level;
    logic       read_only;
    logic       above_priv;
    en         = csr_enables(op, instr);
    level      = priv;
    read_only  = (instr[31:30] == 2'b11) && en[0];
    above_priv = (instr[29:28] > level) && (en != 2'b00);
    return read_only || above_priv;
endfunction

function automatic csr_req_t csr_request(op_e op, logic [xlen-1:0] instr,
                                         logic [xlen-1:0] a, priv_e priv);
    csr_req_t   req;
    logic [1:0] en;
    logic       bad;
    en           = csr_enables(op, instr);
    bad          = csr_violation(op, instr, priv);
    req.address  = instr[31:20];
    req.read_en  = en[1] && !bad;
    req.write_en = en[0] && !bad;
    case (op)
        CSRRW, CSRRWI: req.operation = CSR_WRITE;
        CSRRS, CSRRSI: req.operation = CSR_SET;
        CSRRC, CSRRCI: req.operation = CSR_CLEAR;
        default:       req.operation = CSR_NONE;
    endcase
    req.wdata = (op inside {CSRRW, CSRRS, CSRRC}) ? a : {27'd0, instr[19:15]};
    return req;
endfunction

//////////////////////////////////////////////////
// trap reference
//////////////////////////////////////////////////

function automatic trap_t trap_decision(op_e op, fetch_fault_t f, logic csr_bad,
                                        logic killed, logic irq);
    trap_t t;
    t.raise_exception = 1'b0;
    t.machine_return  = 1'b0;
    t.interrupt_ack   = 1'b0;
    t.code            = EXC_NONE;
    if (killed)
        return t;
    t.raise_exception = 1'b1;
    if (f.fetch_access_fault)
        t.code = EXC_FETCH_ACCESS;
    else if (f.illegal_inst || csr_bad)
        t.code = EXC_ILLEGAL;
    else if (f.misaligned_fetch)
        t.code = EXC_MISALIGNED_FETCH;
    else if (op == ECALL)
        t.code = EXC_ECALL_M;
    else if (op == EBREAK)
        t.code = EXC_BREAKPOINT;
    else begin
        t.raise_exception = 1'b0;
        t.machine_return  = (op == MRET);
        t.interrupt_ack   = (op != MRET) && irq && (op != NOP);
    end
    return t;
endfunction

`endif

// File: bench/tb_execute.sv
// testbench for the execute stage
// random instructions checked against a reference model
`timescale 1ns/1ps

module tb_execute import exec_pkg::*; ();

    localparam int n_instr     = 2000;
    localparam int cycle_limit = n_instr + 4 + 100;

    logic            clk;
    logic            reset;
    logic            stall_i;
    exec_in_t        instr_i;
    fetch_fault_t    fault_i;
    priv_e           privilege_i;
    logic            interrupt_pending_i;
    logic [xlen-1:0] csr_rdata_i;
    csr_req_t        csr_req_o;
    logic            jump_o;
    logic [xlen-1:0] jump_target_o;
    logic            killed_o;
    trap_t           trap_o;
    wb_t             wb_o;

    // model state
    logic [tag_w-1:0] model_tag;
    wb_t              exp_wb;
    logic             wb_valid;
    int               cycle_count = 0;

    `include "execute_model.svh"

    execute_stage UUT (
        .clk                 (clk),
        .reset               (reset),
        .stall_i             (stall_i),
        .instr_i             (instr_i),
        .fault_i             (fault_i),
        .privilege_i         (privilege_i),
        .interrupt_pending_i (interrupt_pending_i),
        .csr_rdata_i         (csr_rdata_i),
        .csr_req_o           (csr_req_o),
        .jump_o              (jump_o),
        .jump_target_o       (jump_target_o),
        .killed_o            (killed_o),
        .trap_o              (trap_o),
        .wb_o                (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // checker and stimulus tasks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_instruction();
        logic [11:0]      csr_addr;
        logic [4:0]       rs1;
        logic [4:0]       rd;
        logic [5:0]       op_sel;
        case ($urandom_range(0, 5))
            0:       csr_addr = 12'h300;
            1:       csr_addr = 12'h341;
            2:       csr_addr = 12'h100;
            3:       csr_addr = 12'h001;
            // read-only counter and hart id
            4:       csr_addr = 12'hc00;
            default: csr_addr = 12'hf14;
        endcase
        rs1    = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
        rd     = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
        op_sel = 6'($urandom_range(0, 36));

        instr_i.instr     = {csr_addr, rs1, 3'($urandom), rd, 7'($urandom)};
        instr_i.pc        = $urandom & 32'hffff_fffc;
        instr_i.op_a      = $urandom;
        instr_i.op_b      = ($urandom_range(0, 3) == 0) ? instr_i.op_a : $urandom;
        instr_i.op_c      = $urandom;
        instr_i.operation = op_e'(op_sel);
        // 80% on the current flow, the rest from a stale one
        if ($urandom_range(0, 9) < 8)
            instr_i.tag = model_tag;
        else
            instr_i.tag = model_tag + 3'($urandom_range(1, 7));

        fault_i.illegal_inst       = ($urandom_range(0, 31) == 0);
        fault_i.misaligned_fetch   = ($urandom_range(0, 31) == 0);
        fault_i.fetch_access_fault = ($urandom_range(0, 31) == 0);
        case ($urandom_range(0, 2))
            0:       privilege_i = USER;
            1:       privilege_i = SUPERVISOR;
            default: privilege_i = MACHINE;
        endcase
        interrupt_pending_i = ($urandom_range(0, 15) == 0);
        stall_i             = ($urandom_range(0, 7) == 0);
        csr_rdata_i         = $urandom;
    endtask

    // same-cycle outputs, then advance the model
    task automatic check_same_cycle();
        op_e      op;
        logic     killed;
        logic     bad;
        logic     jump;
        csr_req_t req;
        trap_t    trap;
        op     = instr_i.operation;
        killed = (instr_i.tag != model_tag);
        bad    = csr_violation(op, instr_i.instr, privilege_i);
        req    = csr_request(op, instr_i.instr, instr_i.op_a, privilege_i);
        trap   = trap_decision(op, fault_i, bad, killed, interrupt_pending_i);
        jump   = branch_taken(op, instr_i.op_a, instr_i.op_b) && !killed;

        check_value("killed_o", xlen'(killed_o), xlen'(killed));
        check_value("jump_o", xlen'(jump_o), xlen'(jump));
        if (op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR})
            check_value("jump_target_o", jump_target_o,
                        branch_target(op, instr_i.op_a, instr_i.op_b, instr_i.op_c, instr_i.pc));
        check_value("csr_req_o.address", xlen'(csr_req_o.address), xlen'(req.address));
        check_value("csr_req_o.read_en", xlen'(csr_req_o.read_en), xlen'(req.read_en));
        check_value("csr_req_o.write_en", xlen'(csr_req_o.write_en), xlen'(req.write_en));
        check_value("csr_req_o.operation", xlen'(csr_req_o.operation), xlen'(req.operation));
        if (op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI})
            check_value("csr_req_o.wdata", csr_req_o.wdata, req.wdata);
        check_value("trap_o.raise_exception", xlen'(trap_o.raise_exception),
                    xlen'(trap.raise_exception));
        check_value("trap_o.machine_return", xlen'(trap_o.machine_return),
                    xlen'(trap.machine_return));
        check_value("trap_o.interrupt_ack", xlen'(trap_o.interrupt_ack),
                    xlen'(trap.interrupt_ack));
        check_value("trap_o.code", xlen'(trap_o.code), xlen'(trap.code));

        if (jump || trap.raise_exception || trap.machine_return || trap.interrupt_ack)
            model_tag = model_tag + 3'd1;
        // a stall keeps the previous writeback
        if (!stall_i) begin
            exp_wb.write_en  = writes_register(op) && !killed;
            exp_wb.operation = op;
            exp_wb.result    = alu_reference(op, instr_i.op_a, instr_i.op_b, instr_i.pc,
                                             csr_rdata_i);
            wb_valid         = 1'b1;
        end
    endtask

    task automatic check_writeback();
        check_value("wb_o.write_en", xlen'(wb_o.write_en), xlen'(exp_wb.write_en));
        if (wb_valid) begin
            check_value("wb_o.operation", xlen'(wb_o.operation), xlen'(exp_wb.operation));
            check_value("wb_o.result", wb_o.result, exp_wb.result);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        reset               = 1'b1;
        stall_i             = 1'b0;
        instr_i             = '0;
        instr_i.operation   = ECALL;
        fault_i             = '0;
        privilege_i         = MACHINE;
        interrupt_pending_i = 1'b0;
        csr_rdata_i         = '0;
        model_tag           = '0;
        exp_wb              = '0;
        wb_valid            = 1'b0;
        void'($urandom(32'h4f37_421e));

        repeat (4) @(posedge clk);
        @(negedge clk);
        // an ecall under reset must not trap
        check_value("trap_o.raise_exception", xlen'(trap_o.raise_exception), 32'd0);
        check_value("trap_o.code", xlen'(trap_o.code), xlen'(EXC_NONE));
        check_value("wb_o.write_en", xlen'(wb_o.write_en), 32'd0);
        reset = 1'b0;

        for (int i = 0; i < n_instr; i++) begin
            check_writeback();
            drive_instruction();
            #10;
            check_same_cycle();
            @(negedge clk);
        end
        check_writeback();

        $display("test passed");
        $finish;
    end

endmodule

// File: rtl/execute_stage.sv
// execute stage of the rv32i core
// alu, branch, csr and trap logic with flow tagging and writeback register
`timescale 1ns/1ps

module execute_stage import exec_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  exec_in_t        instr_i,
    input  fetch_fault_t    fault_i,
    input  priv_e           privilege_i,
    input  logic            interrupt_pending_i,
    input  logic [xlen-1:0] csr_rdata_i,
    output csr_req_t        csr_req_o,
    output logic            jump_o,
    output logic [xlen-1:0] jump_target_o,
    output logic            killed_o,
    output trap_t           trap_o,
    output wb_t             wb_o
);

    logic [tag_w-1:0] curr_tag;
    logic             killed;
    logic             take;
    logic             csr_illegal;
    logic             write_en;
    logic [xlen-1:0]  alu_result;

    alu u_alu (
        .op_i        (instr_i.operation),
        .a_i         (instr_i.op_a),
        .b_i         (instr_i.op_b),
        .c_i         (instr_i.op_c),
        .pc_i        (instr_i.pc),
        .csr_rdata_i (csr_rdata_i),
        .result_o    (alu_result)
    );

    branch_unit u_branch (
        .op_i     (instr_i.operation),
        .a_i      (instr_i.op_a),
        .b_i      (instr_i.op_b),
        .c_i      (instr_i.op_c),
        .pc_i     (instr_i.pc),
        .take_o   (take),
        .target_o (jump_target_o)
    );

    // enables come back already gated by the illegal check
    csr_access u_csr (
        .op_i        (instr_i.operation),
        .instr_i     (instr_i.instr),
        .a_i         (instr_i.op_a),
        .privilege_i (privilege_i),
        .req_o       (csr_req_o),
        .illegal_o   (csr_illegal)
    );

    trap_control u_trap (
        .op_i                (instr_i.operation),
        .fault_i             (fault_i),
        .csr_illegal_i       (csr_illegal),
        .killed_i            (killed),
        .reset_i             (reset),
        .interrupt_pending_i (interrupt_pending_i),
        .trap_o              (trap_o)
    );

    //////////////////////////////////////////////////
    // flow tag and kill
    //////////////////////////////////////////////////

    assign killed   = (instr_i.tag != curr_tag);
    assign killed_o = killed;
    assign jump_o   = take && !killed;

    // new flow after any redirect, wraps mod 8
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_o || trap_o.raise_exception || trap_o.machine_return ||
                     trap_o.interrupt_ack) begin
            curr_tag <= curr_tag + tag_w'(1);
        end
    end

    //////////////////////////////////////////////////
    // writeback register
    //////////////////////////////////////////////////

    // stores and conditional branches have no destination
    always_comb begin
        if (instr_i.operation inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU}) begin
            write_en = 1'b0;
        end else begin
            write_en = !killed;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_o.write_en <= 1'b0;
        end else if (!stall_i) begin
            wb_o.write_en <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_o.operation <= instr_i.operation;
            wb_o.result    <= alu_result;
        end
    end

endmodule

// File: rtl/trap_control.sv
// trap control, prioritised exceptions, mret and interrupt acknowledge
`timescale 1ns/1ps

module trap_control import exec_pkg::*; (
    input  op_e          op_i,
    input  fetch_fault_t fault_i,
    input  logic         csr_illegal_i,
    input  logic         killed_i,
    input  logic         reset_i,
    input  logic         interrupt_pending_i,
    output trap_t        trap_o
);

    always_comb begin
        trap_o.raise_exception = 1'b0;
        trap_o.machine_return  = 1'b0;
        trap_o.interrupt_ack   = 1'b0;
        trap_o.code            = EXC_NONE;

        // killed instructions never trap
        if (!reset_i && !killed_i) begin
            if (fault_i.fetch_access_fault) begin
                trap_o.raise_exception = 1'b1;
                trap_o.code            = EXC_FETCH_ACCESS;
            end else if (fault_i.illegal_inst || csr_illegal_i) begin
                trap_o.raise_exception = 1'b1;
                trap_o.code            = EXC_ILLEGAL;
            end else if (fault_i.misaligned_fetch) begin
                trap_o.raise_exception = 1'b1;
                trap_o.code            = EXC_MISALIGNED_FETCH;
            end else if (op_i == ECALL) begin
                trap_o.raise_exception = 1'b1;
                trap_o.code            = EXC_ECALL_M;
            end else if (op_i == EBREAK) begin
                trap_o.raise_exception = 1'b1;
                trap_o.code            = EXC_BREAKPOINT;
            end else if (op_i == MRET) begin
                trap_o.machine_return = 1'b1;
            end else if (interrupt_pending_i && op_i != NOP) begin
                // a bubble cannot take the interrupt
                trap_o.interrupt_ack = 1'b1;
            end
        end
    end

endmodule

// File: rtl/csr_access.sv
// csr access, request to the csr file and the illegal address check
`timescale 1ns/1ps

module csr_access import exec_pkg::*; (
    input  op_e             op_i,
    input  logic [xlen-1:0] instr_i,
    input  logic [xlen-1:0] a_i,
    input  priv_e           privilege_i,
    output csr_req_t        req_o,
    output logic            illegal_o
);

    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [csr_addr_w-1:0] addr;
    logic                  rd_en;
    logic                  wr_en;

    assign rd   = instr_i[11:7];
    assign rs1  = instr_i[19:15];
    assign addr = instr_i[31:20];

    // write forms skip the read when rd is x0
    // set and clear forms skip the write when rs1 is x0
    always_comb begin
        case (op_i)
            CSRRW, CSRRWI: begin
                rd_en = (rd != '0);
                wr_en = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                rd_en = 1'b1;
                wr_en = (rs1 != '0);
            end
            default: begin
                rd_en = 1'b0;
                wr_en = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // permission check
    //////////////////////////////////////////////////

    always_comb begin
        if (addr[11:10] == 2'b11 && wr_en) begin
            // read-only address space
            illegal_o = 1'b1;
        end else if (addr[9:8] > 2'(privilege_i) && (rd_en || wr_en)) begin
            illegal_o = 1'b1;
        end else begin
            illegal_o = 1'b0;
        end
    end

    always_comb begin
        req_o.address  = addr;
        req_o.read_en  = rd_en && !illegal_o;
        req_o.write_en = wr_en && !illegal_o;
        case (op_i)
            CSRRW, CSRRWI: req_o.operation = CSR_WRITE;
            CSRRS, CSRRSI: req_o.operation = CSR_SET;
            CSRRC, CSRRCI: req_o.operation = CSR_CLEAR;
            default:       req_o.operation = CSR_NONE;
        endcase
        // immediate forms carry the zero-extended rs1 field
        case (op_i)
            CSRRW, CSRRS, CSRRC: req_o.wdata = a_i;
            default:             req_o.wdata = {{(xlen-5){1'b0}}, rs1};
        endcase
    end

endmodule

// File: rtl/branch_unit.sv
// branch unit, condition evaluation and jump target
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  op_e             op_i,
    input  logic [xlen-1:0] a_i,
    input  logic [xlen-1:0] b_i,
    input  logic [xlen-1:0] c_i,
    input  logic [xlen-1:0] pc_i,
    output logic            take_o,
    output logic [xlen-1:0] target_o
);

    logic            eq;
    logic            lt;
    logic            ltu;
    logic [xlen-1:0] reg_target;

    assign eq  = (a_i == b_i);
    assign lt  = $signed(a_i) < $signed(b_i);
    assign ltu = (a_i < b_i);

    assign reg_target = a_i + b_i;

    always_comb begin
        case (op_i)
            BEQ:       take_o = eq;
            BNE:       take_o = !eq;
            BLT:       take_o = lt;
            BLTU:      take_o = ltu;
            BGE:       take_o = !lt;
            BGEU:      take_o = !ltu;
            JAL, JALR: take_o = 1'b1;
            default:   take_o = 1'b0;
        endcase
    end

    // jalr clears bit 0, conditional branches are pc relative
    always_comb begin
        case (op_i)
            JALR:    target_o = {reg_target[xlen-1:1], 1'b0};
            JAL:     target_o = reg_target;
            default: target_o = pc_i + c_i;
        endcase
    end

endmodule

// File: rtl/alu.sv
// integer alu for the execute stage
// arithmetic, logic, shifts, compares and the result select
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  op_e             op_i,
    input  logic [xlen-1:0] a_i,
    input  logic [xlen-1:0] b_i,
    input  logic [xlen-1:0] c_i,
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] csr_rdata_i,
    output logic [xlen-1:0] result_o
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] sum2_a;
    logic [xlen-1:0] sum2_b;
    logic [xlen-1:0] sum2;
    logic [xlen-1:0] sll_res;
    logic [xlen-1:0] srl_res;
    logic [xlen-1:0] sra_res;
    logic            lt;
    logic            ltu;

    // second adder, link address or a - b
    always_comb begin
        sum2_a = (op_i == SUB) ? a_i : pc_i;
        case (op_i)
            JAL, JALR: sum2_b = xlen'(4);
            SUB:       sum2_b = ~b_i + xlen'(1);
            default:   sum2_b = c_i;
        endcase
    end

    always_comb begin
        sum     = a_i + b_i;
        sum2    = sum2_a + sum2_b;
        sll_res = a_i << b_i[4:0];
        srl_res = a_i >> b_i[4:0];
        sra_res = $signed(a_i) >>> b_i[4:0];
        lt      = $signed(a_i) < $signed(b_i);
        ltu     = a_i < b_i;
    end

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result_o = csr_rdata_i;
            JAL, JALR, SUB:         result_o = sum2;
            SLT:                    result_o = {{(xlen-1){1'b0}}, lt};
            SLTU:                   result_o = {{(xlen-1){1'b0}}, ltu};
            XOR:                    result_o = a_i ^ b_i;
            OR:                     result_o = a_i | b_i;
            AND:                    result_o = a_i & b_i;
            SLL:                    result_o = sll_res;
            SRL:                    result_o = srl_res;
            SRA:                    result_o = sra_res;
            LUI:                    result_o = b_i;
            // add, loads and stores take the address sum
            default:                result_o = sum;
        endcase
    end

endmodule

// File: rtl/exec_pkg.sv
// execute stage package
// widths, operation and exception codes, and the port structs

package exec_pkg;

    localparam int xlen       = 32;
    localparam int tag_w      = 3;
    localparam int csr_addr_w = 12;

    //////////////////////////////////////////////////
    // enumerations
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // arithmetic and logic
        NOP, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI,
        // branches and jumps
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        // loads and stores
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        // csr
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        // system
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    // mcause encodings
    typedef enum logic [4:0] {
        EXC_MISALIGNED_FETCH = 5'd0,
        EXC_FETCH_ACCESS     = 5'd1,
        EXC_ILLEGAL          = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_ECALL_M          = 5'd11,
        EXC_NONE             = 5'd31
    } exc_code_e;

    //////////////////////////////////////////////////
    // port structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [xlen-1:0]  instr;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  op_a;
        logic [xlen-1:0]  op_b;
        logic [xlen-1:0]  op_c;
        op_e              operation;
        logic [tag_w-1:0] tag;
    } exec_in_t;

    typedef struct packed {
        logic illegal_inst;
        logic misaligned_fetch;
        logic fetch_access_fault;
    } fetch_fault_t;

    typedef struct packed {
        logic [csr_addr_w-1:0] address;
        logic                  read_en;
        logic                  write_en;
        csr_op_e               operation;
        logic [xlen-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic      raise_exception;
        logic      machine_return;
        logic      interrupt_ack;
        exc_code_e code;
    } trap_t;

    typedef struct packed {
        logic            write_en;
        op_e             operation;
        logic [xlen-1:0] result;
    } wb_t;

endpackage
